//--- design/cpAgu.sv
`timescale 1ns/1ps

module cpAgu (
  input  logic               iClk,
  input  logic               rstN,
  input  cpPipePkg::memOpT   memOp,
  output cpPipePkg::dmemReqT dmemReq
);

  import cpIsaPkg::*;
  import cpPipePkg::*;

  logic [dataWidth-1:0]    addr;
  logic [byteSelWidth-1:0] byteSel;
  logic [dataWidth-1:0]    laneData;

  assign addr = memOp.base + memOp.offset;

  // Lane select and store data alignment
  always_comb begin
    case (memOp.size)
      sizeHalf: begin
        byteSel  = addr[1] ? 4'b1100 : 4'b0011;
        laneData = {16'b0, memOp.storeData[15:0]} << {addr[1], 4'b0};
      end
      sizeByte: begin
        byteSel  = 4'b0001 << addr[1:0];
        laneData = {24'b0, memOp.storeData[7:0]} << {addr[1:0], 3'b0};
      end
      default: begin
        byteSel  = '1;                              // Full word
        laneData = memOp.storeData;
      end
    endcase
  end

  always_ff @(posedge iClk or negedge rstN) begin
    if (!rstN)
      dmemReq <= '0;                                // No strobe out of reset
    else
      dmemReq <= '{we: memOp.we, re: memOp.re, addr: addr,
                   byteSel: byteSel, wdata: laneData};
  end

  // A single access per cycle
  assert property (@(posedge iClk) disable iff (!rstN)
    !(dmemReq.we && dmemReq.re));

endmodule

//--- design/cpBypass.sv
`timescale 1ns/1ps

module cpBypass (
  input  logic [cpIsaPkg::rfIndexWidth-1:0] readAddrA,
  input  logic [cpIsaPkg::rfIndexWidth-1:0] readAddrB,
  input  logic                              selectImm,
  input  logic [cpIsaPkg::dataWidth-1:0]    immediate,
  input  logic [cpIsaPkg::dataWidth-1:0]    readDataA,
  input  logic [cpIsaPkg::dataWidth-1:0]    readDataB,
  input  cpPipePkg::rfWriteT                exResult,   // Youngest, wins
  input  cpPipePkg::rfWriteT                wbWrite,
  output logic [cpIsaPkg::dataWidth-1:0]    operandA,
  output logic [cpIsaPkg::dataWidth-1:0]    operandB,
  output logic [cpIsaPkg::dataWidth-1:0]    storeData
);

  import cpIsaPkg::*;
  import cpPipePkg::*;

  logic [dataWidth-1:0] fwdA;
  logic [dataWidth-1:0] fwdB;

  // Same priority mux for both read ports
  function automatic logic [dataWidth-1:0] forward(
    input logic [rfIndexWidth-1:0] addr,
    input logic [dataWidth-1:0]    raw,
    input rfWriteT                 ex,
    input rfWriteT                 wb
  );
    if (addr == '0)
      return '0;                                   // r0 never forwarded
    if (ex.we && (ex.addr == addr))
      return ex.data;
    if (wb.we && (wb.addr == addr))
      return wb.data;
    return raw;
  endfunction

  always_comb begin
    fwdA = forward(readAddrA, readDataA, exResult, wbWrite);
    fwdB = forward(readAddrB, readDataB, exResult, wbWrite);
  end

  assign operandA  = fwdA;
  assign operandB  = selectImm ? immediate : fwdB;
  assign storeData = fwdB;                          // Store reg sits on port B

endmodule

//--- design/cpDecode.sv
`timescale 1ns/1ps

module cpDecode (
  input  logic                              iClk,
  input  logic                              rstN,
  input  logic [cpIsaPkg::pcWidth-1:0]      pc,
  input  cpIsaPkg::insFieldsT               instruction,
  input  logic [cpIsaPkg::dataWidth-1:0]    operandA,     // Forwarded
  input  logic [cpIsaPkg::dataWidth-1:0]    operandB,     // Forwarded or immediate
  input  logic [cpIsaPkg::dataWidth-1:0]    storeData,
  input  logic                              flagNext,     // Includes compare in EX
  output logic [cpIsaPkg::rfIndexWidth-1:0] readAddrA,
  output logic [cpIsaPkg::rfIndexWidth-1:0] readAddrB,
  output logic                              selectImm,
  output logic [cpIsaPkg::dataWidth-1:0]    immediate,
  output logic                              branchTaken,
  output logic [cpIsaPkg::pcWidth-1:0]      branchTarget,
  output cpPipePkg::memOpT                  memOp,
  output cpPipePkg::idExT                   idEx,
  output logic                              taskFinished
);

  import cpIsaPkg::*;
  import cpPipePkg::*;

  logic    live;                                 // Low once HALT has retired
  logic    isAluOp;
  logic    isLoadOp;
  logic    isStoreOp;
  logic    rfWe;
  logic    takeBranch;
  aluOpE   aluCode;
  cmpKindE cmpCode;
  memSizeE memSize;

  assign live      = !taskFinished;
  assign isAluOp   = instruction.opcode inside {opAdd, opSub, opAnd, opOr, opXor, opAddi};
  assign isLoadOp  = instruction.opcode inside {opLw, opLhu, opLbu};
  assign isStoreOp = instruction.opcode inside {opSw, opSh, opSb};
  assign rfWe      = (isAluOp || isLoadOp) && (instruction.rd != '0) && live;

  // **************************************************
  // Opcode decode
  // **************************************************
  always_comb begin
    case (instruction.opcode)
      opAdd, opAddi: aluCode = aluAdd;
      opSub:         aluCode = aluSub;
      opAnd:         aluCode = aluAnd;
      opOr:          aluCode = aluOr;
      opXor:         aluCode = aluXor;
      default:       aluCode = aluPass;
    endcase
    case (instruction.opcode)
      opSfeq:  cmpCode = cmpEq;
      opSfltu: cmpCode = cmpLtu;
      default: cmpCode = cmpNone;
    endcase
    case (instruction.opcode)
      opLhu, opSh: memSize = sizeHalf;
      opLbu, opSb: memSize = sizeByte;
      default:     memSize = sizeWord;
    endcase
    case (instruction.opcode)
      opBf:    takeBranch = flagNext;            // Flag may come from EX this cycle
      opBnf:   takeBranch = !flagNext;
      opJ:     takeBranch = 1'b1;
      default: takeBranch = 1'b0;
    endcase
  end

  // Register read and immediate
  assign readAddrA = instruction.ra;
  assign readAddrB = isStoreOp ? instruction.rd : instruction.imm[immWidth-1 -: rfIndexWidth];
  assign selectImm = isLoadOp || isStoreOp || (instruction.opcode == opAddi);
  assign immediate = {{(dataWidth-immWidth){instruction.imm[immWidth-1]}}, instruction.imm};

  // Branch redirect to IF
  assign branchTaken  = takeBranch && live;
  assign branchTarget = instruction.imm[pcWidth-1:0];

  // AGU registers this on the same edge as idEx
  assign memOp = '{we: isStoreOp && live, re: isLoadOp && live, size: memSize,
                   base: operandA, offset: immediate, storeData: storeData};

  // **************************************************
  // ID/EX register and task end
  // **************************************************
  always_ff @(posedge iClk or negedge rstN) begin
    if (!rstN) begin
      idEx         <= '0;
      taskFinished <= 1'b0;
    end else begin
      idEx <= '{aluOp: aluCode, opA: operandA, opB: operandB, rd: instruction.rd,
                we: rfWe, cmpKind: live ? cmpCode : cmpNone,
                isLoad: isLoadOp && live, loadSize: memSize};
      taskFinished <= taskFinished || (instruction.opcode == opHalt);  // Sticky
    end
  end

  // Fetch hands over only defined opcodes
  assert property (@(posedge iClk) disable iff (!rstN)
    instruction.opcode inside {[opNop:opHalt]});

  // One squashed slot, then the target reaches ID
  assert property (@(posedge iClk) disable iff (!rstN)
    branchTaken |=> ##1 (pc == $past(branchTarget, 2)));

endmodule

//--- design/cpExecute.sv
`timescale 1ns/1ps

module cpExecute (
  input  logic                           iClk,
  input  logic                           rstN,
  input  cpPipePkg::idExT                idEx,
  input  logic [1:0]                     dmemAddrLow,   // Low byte address of the load
  input  logic [cpIsaPkg::dataWidth-1:0] dmemReadData,  // Async DMEM read data
  output cpPipePkg::rfWriteT             exResult,      // Forwarded from EX
  output logic                           flagNext,
  output cpPipePkg::rfWriteT             wbWrite
);

  import cpIsaPkg::*;
  import cpPipePkg::*;

  logic                 flag;
  logic [dataWidth-1:0] aluResult;
  logic [dataWidth-1:0] loadData;
  logic [dataWidth-1:0] shiftedLoad;

  // **************************************************
  // ALU
  // **************************************************
  always_comb begin
    case (idEx.aluOp)
      aluAdd:  aluResult = idEx.opA + idEx.opB;
      aluSub:  aluResult = idEx.opA - idEx.opB;
      aluAnd:  aluResult = idEx.opA & idEx.opB;
      aluOr:   aluResult = idEx.opA | idEx.opB;
      aluXor:  aluResult = idEx.opA ^ idEx.opB;
      default: aluResult = idEx.opB;
    endcase
  end

  // Compare result is visible to a branch in ID right away
  always_comb begin
    case (idEx.cmpKind)
      cmpEq:   flagNext = (idEx.opA == idEx.opB);
      cmpLtu:  flagNext = (idEx.opA < idEx.opB);  // Unsigned
      default: flagNext = flag;
    endcase
  end

  always_ff @(posedge iClk or negedge rstN) begin
    if (!rstN)
      flag <= 1'b0;
    else
      flag <= flagNext;
  end

  // **************************************************
  // Load merge and EX/WB
  // **************************************************
  assign shiftedLoad = dmemReadData >> {dmemAddrLow, 3'b0};

  always_comb begin
    case (idEx.loadSize)
      sizeHalf: loadData = {16'b0, shiftedLoad[15:0]};
      sizeByte: loadData = {24'b0, shiftedLoad[7:0]};
      default:  loadData = dmemReadData;
    endcase
  end

  assign exResult = '{we: idEx.we, addr: idEx.rd,
                      data: idEx.isLoad ? loadData : aluResult};

  always_ff @(posedge iClk or negedge rstN) begin
    if (!rstN)
      wbWrite <= '0;
    else
      wbWrite <= exResult;
  end

endmodule

//--- design/cpFetch.sv
`timescale 1ns/1ps

module cpFetch (
  input  logic                         iClk,
  input  logic                         rstN,
  input  logic [cpIsaPkg::insWidth-1:0] imemData,     // Async IMEM read data
  input  logic                         branchTaken,
  input  logic [cpIsaPkg::pcWidth-1:0] branchTarget,
  input  logic                         taskFinished,  // Freezes the front end
  output logic [cpIsaPkg::pcWidth-1:0] imemAddr,
  output logic [cpIsaPkg::pcWidth-1:0] pc,            // PC of the instruction in ID
  output cpIsaPkg::insFieldsT          instruction
);

  import cpIsaPkg::*;

  logic [pcWidth-1:0] fetchPc;                        // PC in IF

  assign imemAddr = fetchPc;

  always_ff @(posedge iClk or negedge rstN) begin
    if (!rstN) begin
      fetchPc     <= '0;
      pc          <= '0;
      instruction <= nopIns;                          // ID starts empty
    end else if (!taskFinished) begin
      fetchPc <= branchTaken ? branchTarget : fetchPc + 1'b1;
      pc      <= fetchPc;
      if (branchTaken)
        instruction <= nopIns;                        // Squash the fall-through slot
      else
        instruction <= insFieldsT'(imemData);
    end
  end

  // Front end holds still once the program has ended
  assert property (@(posedge iClk) disable iff (!rstN)
    taskFinished |=> $stable(imemAddr) && $stable(pc));

endmodule

//--- design/cpIsaPkg.sv
package cpIsaPkg;

  // **************************************************
  // Widths
  // **************************************************
  localparam int dataWidth    = 32;                   // Datapath
  localparam int insWidth     = 24;                   // One instruction word
  localparam int pcWidth      = 10;                   // IMEM word address
  localparam int rfIndexWidth = 4;                    // 16 registers
  localparam int rfDepth      = 1 << rfIndexWidth;
  localparam int immWidth     = 11;                   // Short immediate, overlays rb
  localparam int byteSelWidth = dataWidth / 8;        // One bit per byte lane

  // **************************************************
  // Opcodes and sub-codes
  // **************************************************
  typedef enum logic [4:0] {
    opNop   = 5'd0,
    opAdd, opSub, opAnd, opOr, opXor,                 // Register-register ALU
    opAddi,                                           // rd = ra + sext(imm)
    opSfeq, opSfltu,                                  // Compares, set flag only
    opLw, opLhu, opLbu,                               // Loads, sub-word zero-extended
    opSw, opSh, opSb,                                 // Stores, data reg in rd field
    opBf, opBnf, opJ,                                 // Absolute targets
    opHalt
  } cpOpcodeE;

  typedef enum logic [2:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluXor, aluPass
  } aluOpE;

  typedef enum logic [1:0] {
    sizeWord, sizeHalf, sizeByte
  } memSizeE;

  // Instruction layout, rb is imm[10:7]
  typedef struct packed {
    cpOpcodeE              opcode;                    // 23:19
    logic [rfIndexWidth-1:0] rd;                      // 18:15, store data reg too
    logic [rfIndexWidth-1:0] ra;                      // 14:11
    logic [immWidth-1:0]     imm;                     // 10:0
  } insFieldsT;

  localparam insFieldsT nopIns = '{opcode: opNop, rd: '0, ra: '0, imm: '0};

endpackage

//--- design/cpPipePkg.sv
package cpPipePkg;

  typedef enum logic [1:0] {
    cmpNone, cmpEq, cmpLtu
  } cmpKindE;

  // Register file write port, also the forwarding source
  typedef struct packed {
    logic                                we;
    logic [cpIsaPkg::rfIndexWidth-1:0]   addr;
    logic [cpIsaPkg::dataWidth-1:0]      data;
  } rfWriteT;

  // ID/EX stage register
  typedef struct packed {
    cpIsaPkg::aluOpE                     aluOp;
    logic [cpIsaPkg::dataWidth-1:0]      opA;
    logic [cpIsaPkg::dataWidth-1:0]      opB;
    logic [cpIsaPkg::rfIndexWidth-1:0]   rd;
    logic                                we;      // RF write, never for r0
    cmpKindE                             cmpKind;
    logic                                isLoad;  // Result comes from DMEM
    cpIsaPkg::memSizeE                   loadSize;
  } idExT;

  // Load/store request out of decode, before address generation
  typedef struct packed {
    logic                                we;
    logic                                re;
    cpIsaPkg::memSizeE                   size;
    logic [cpIsaPkg::dataWidth-1:0]      base;
    logic [cpIsaPkg::dataWidth-1:0]      offset;
    logic [cpIsaPkg::dataWidth-1:0]      storeData;
  } memOpT;

  // Registered DMEM request, valid in EX
  typedef struct packed {
    logic                                we;
    logic                                re;
    logic [cpIsaPkg::dataWidth-1:0]      addr;    // Byte address
    logic [cpIsaPkg::byteSelWidth-1:0]   byteSel;
    logic [cpIsaPkg::dataWidth-1:0]      wdata;   // Already in its lane
  } dmemReqT;

endpackage

//--- design/cpRegFile.sv
`timescale 1ns/1ps

module cpRegFile (
  input  logic                              iClk,
  input  logic                              rstN,
  input  logic [cpIsaPkg::rfIndexWidth-1:0] readAddrA,
  input  logic [cpIsaPkg::rfIndexWidth-1:0] readAddrB,
  input  cpPipePkg::rfWriteT                wbWrite,
  output logic [cpIsaPkg::dataWidth-1:0]    readDataA,
  output logic [cpIsaPkg::dataWidth-1:0]    readDataB
);

  import cpIsaPkg::*;

  logic [dataWidth-1:0] regs [rfDepth];

  always_ff @(posedge iClk) begin
    if (wbWrite.we)
      regs[wbWrite.addr] <= wbWrite.data;
  end

  // Async read, r0 hardwired
  assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
  assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

  // Decode never schedules a write to r0
  assert property (@(posedge iClk) disable iff (!rstN)
    !(wbWrite.we && (wbWrite.addr == '0)));

endmodule

//--- design/cpTop.sv
`timescale 1ns/1ps

module cpTop (
  input  logic                           iClk,
  input  logic                           rstN,
  output logic [cpIsaPkg::pcWidth-1:0]   imemAddr,
  input  logic [cpIsaPkg::insWidth-1:0]  imemData,
  output logic [cpIsaPkg::pcWidth-1:0]   pc,            // ID stage PC, for debug
  output logic                           taskFinished,
  output cpPipePkg::dmemReqT             dmemReq,
  input  logic [cpIsaPkg::dataWidth-1:0] dmemReadData
);

  import cpIsaPkg::*;
  import cpPipePkg::*;

  insFieldsT               instruction;
  logic                    branchTaken;
  logic [pcWidth-1:0]      branchTarget;
  logic [rfIndexWidth-1:0] readAddrA;
  logic [rfIndexWidth-1:0] readAddrB;
  logic [dataWidth-1:0]    readDataA;
  logic [dataWidth-1:0]    readDataB;
  logic [dataWidth-1:0]    operandA;
  logic [dataWidth-1:0]    operandB;
  logic [dataWidth-1:0]    storeData;
  logic [dataWidth-1:0]    immediate;
  logic                    selectImm;
  logic                    flagNext;
  memOpT                   memOp;
  idExT                    idEx;
  rfWriteT                 exResult;
  rfWriteT                 wbWrite;

  // **************************************************
  // IF and ID
  // **************************************************
  cpFetch instFetch (
    .iClk, .rstN, .imemData, .branchTaken, .branchTarget, .taskFinished,
    .imemAddr, .pc, .instruction
  );

  cpDecode instDecode (
    .iClk, .rstN, .pc, .instruction, .operandA, .operandB, .storeData, .flagNext,
    .readAddrA, .readAddrB, .selectImm, .immediate, .branchTaken, .branchTarget,
    .memOp, .idEx, .taskFinished
  );

  cpRegFile instRegFile (
    .iClk, .rstN, .readAddrA, .readAddrB, .wbWrite, .readDataA, .readDataB
  );

  cpBypass instBypass (
    .readAddrA, .readAddrB, .selectImm, .immediate, .readDataA, .readDataB,
    .exResult, .wbWrite, .operandA, .operandB, .storeData
  );

  // **************************************************
  // Memory access and EX
  // **************************************************
  cpAgu instAgu (
    .iClk, .rstN, .memOp, .dmemReq
  );

  cpExecute instExecute (
    .iClk,
    .rstN,
    .idEx,
    .dmemAddrLow  (dmemReq.addr[1:0]),            // Same cycle as the load in EX
    .dmemReadData,
    .exResult,
    .flagNext,
    .wbWrite
  );

endmodule

//--- run.sh
#!/bin/sh
# Compile and run the cpTb simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module cpTb -o cpTbSim

output=$(./obj_dir/cpTbSim)
echo "$output"

if echo "$output" | grep -q "^TESTBENCH PASSED$"; then
  exit 0
else
  exit 1
fi

//--- tb.f
design/cpIsaPkg.sv
design/cpPipePkg.sv
design/cpFetch.sv
design/cpDecode.sv
design/cpRegFile.sv
design/cpBypass.sv
design/cpAgu.sv
design/cpExecute.sv
design/cpTop.sv
test/cpTb.sv

//--- test/cpTb.sv
`timescale 1ns/1ps

module cpTb;

  import cpIsaPkg::*;
  import cpPipePkg::*;

  localparam int clkPeriod   = 8;
  localparam int resetCycles = 8;
  localparam int drainCycles = 4;                     // Lets EX and WB empty after HALT
  localparam int numTests    = 6;
  localparam int maxIns      = 16;
  localparam int maxStores   = 8;

  typedef struct packed {
    logic [dataWidth-1:0]    addr;
    logic [byteSelWidth-1:0] sel;
    logic [dataWidth-1:0]    data;
  } storeRecT;

  logic                 iClk;
  logic                 rstN;
  logic [pcWidth-1:0]   imemAddr;
  logic [insWidth-1:0]  imemData;
  logic [pcWidth-1:0]   pc;
  logic                 taskFinished;
  dmemReqT              dmemReq;
  logic [dataWidth-1:0] dmemReadData;

  logic [insWidth-1:0]  imem [1024];
  logic [dataWidth-1:0] dmem [256];
  logic [insWidth-1:0]  progTable [numTests][maxIns];   // Program per test
  int                   progLen [numTests];
  storeRecT             expTable [numTests][maxStores]; // Expected stores in order
  int                   expCount [numTests];
  int                   expLoadCount [numTests];        // Loads on the executed path
  storeRecT             seenQ [$];                      // Stores the DUT issued
  int                   loadCount;                      // Read strobes the DUT issued
  int                   valueErrors;
  int                   otherErrors;

  cpTop DUT (
    .iClk, .rstN, .imemAddr, .imemData, .pc, .taskFinished, .dmemReq, .dmemReadData
  );

  initial begin
    iClk = 1'b0;
    forever #(clkPeriod / 2) iClk = ~iClk;
  end

  // **************************************************
  // Memory models
  // **************************************************
  assign imemData     = imem[imemAddr];                 // Async read
  assign dmemReadData = dmem[dmemReq.addr[9:2]];

  always @(posedge iClk) begin
    if (dmemReq.re)
      loadCount++;
    if (dmemReq.we) begin
      seenQ.push_back('{addr: dmemReq.addr, sel: dmemReq.byteSel, data: dmemReq.wdata});
      for (int b = 0; b < byteSelWidth; b++)
        if (dmemReq.byteSel[b])
          dmem[dmemReq.addr[9:2]][8*b +: 8] <= dmemReq.wdata[8*b +: 8];
    end
  end

  // **************************************************
  // Encoding and table helpers
  // **************************************************
  function automatic logic [insWidth-1:0] encode(input cpOpcodeE op, input int rd,
                                                 input int ra, input int imm);
    return {op, rd[3:0], ra[3:0], imm[10:0]};
  endfunction

  function automatic logic [insWidth-1:0] rrIns(input cpOpcodeE op, input int rd,
                                                input int ra, input int rb);
    return encode(op, rd, ra, rb * 128);                // rb lives in imm[10:7]
  endfunction

  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};    // x^16+x^14+x^13+x^11+1
  endfunction

  task automatic addIns(input int t, input logic [insWidth-1:0] word);
    progTable[t][progLen[t]] = word;
    progLen[t]++;
  endtask

  task automatic expectStore(input int t, input int addr, input logic [3:0] sel,
                             input logic [dataWidth-1:0] data);
    expTable[t][expCount[t]] = '{addr: 32'(addr), sel: sel, data: data};
    expCount[t]++;
  endtask

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got === exp) else begin
      valueErrors++;
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  // **************************************************
  // Program table
  // **************************************************
  task automatic buildTable();
    logic [31:0] a, b, c, d, e, f, g, h;
    logic [31:0] v;
    logic [31:0] w;
    logic [31:0] acc;
    logic [15:0] lfsr;
    logic [10:0] imm;
    for (int t = 0; t < numTests; t++) begin
      progLen[t]      = 0;
      expCount[t]     = 0;
      expLoadCount[t] = 0;
    end
    // Test 0 ALU chain, every operand forwarded
    a = 32'd100;
    b = a - 32'd7;
    c = a + b;
    d = c - a;
    e = d & c;
    f = e | b;
    g = f ^ c;
    h = a - c;                                          // Negative result
    addIns(0, encode(opAddi, 1, 0, 100));
    addIns(0, encode(opAddi, 2, 1, -7));
    addIns(0, rrIns(opAdd, 3, 1, 2));
    addIns(0, rrIns(opSub, 4, 3, 1));
    addIns(0, rrIns(opAnd, 5, 4, 3));
    addIns(0, rrIns(opOr, 6, 5, 2));
    addIns(0, rrIns(opXor, 7, 6, 3));
    addIns(0, rrIns(opSub, 8, 1, 3));
    addIns(0, encode(opSw, 3, 0, 'h10));
    addIns(0, encode(opSw, 7, 0, 'h14));
    addIns(0, encode(opSw, 8, 0, 'h18));
    addIns(0, encode(opHalt, 0, 0, 0));
    expectStore(0, 'h10, 4'b1111, c);
    expectStore(0, 'h14, 4'b1111, g);
    expectStore(0, 'h18, 4'b1111, h);
    // Test 1 byte and half lanes
    v = 32'd677;
    addIns(1, encode(opAddi, 1, 0, 677));
    addIns(1, encode(opAddi, 2, 0, 'h20));              // Base register
    for (int k = 0; k < 4; k++) begin
      addIns(1, encode(opSb, 1, 2, k));
      expectStore(1, 'h20 + k, 4'b0001 << k, {24'b0, v[7:0]} << (8 * k));
    end
    addIns(1, encode(opSh, 1, 2, 4));
    addIns(1, encode(opSh, 1, 2, 6));
    addIns(1, encode(opHalt, 0, 0, 0));
    expectStore(1, 'h24, 4'b0011, {16'b0, v[15:0]});
    expectStore(1, 'h26, 4'b1100, {v[15:0], 16'b0});
    // Test 2 store, reload zero-extended, store again
    w = 32'hFFFF_FFA5;
    addIns(2, encode(opAddi, 1, 0, -91));
    addIns(2, encode(opSw, 1, 0, 'h40));
    addIns(2, encode(opLbu, 2, 0, 'h40));
    addIns(2, encode(opSw, 2, 0, 'h44));                // Load data forwarded from EX
    addIns(2, encode(opLhu, 3, 0, 'h42));
    addIns(2, encode(opSw, 3, 0, 'h48));
    addIns(2, encode(opLw, 4, 0, 'h40));
    addIns(2, rrIns(opAdd, 5, 4, 2));
    addIns(2, encode(opSw, 5, 0, 'h4C));
    addIns(2, encode(opHalt, 0, 0, 0));
    expectStore(2, 'h40, 4'b1111, w);
    expectStore(2, 'h44, 4'b1111, {24'b0, w[7:0]});
    expectStore(2, 'h48, 4'b1111, {16'b0, w[31:16]});
    expectStore(2, 'h4C, 4'b1111, w + {24'b0, w[7:0]});
    expLoadCount[2] = 3;                                // LBU, LHU, LW
    // Test 3 compare then branch, only the taken path stores
    addIns(3, encode(opAddi, 1, 0, 5));
    addIns(3, encode(opAddi, 2, 0, 9));
    addIns(3, rrIns(opSfltu, 0, 1, 2));                 // 5 < 9 sets flag
    addIns(3, encode(opBf, 0, 0, 6));
    addIns(3, encode(opSw, 1, 0, 'h60));                // Squashed slot
    addIns(3, encode(opSw, 1, 0, 'h64));
    addIns(3, rrIns(opSfeq, 0, 1, 2));                  // Clears flag
    addIns(3, encode(opBf, 0, 0, 10));
    addIns(3, encode(opSw, 2, 0, 'h68));
    addIns(3, encode(opBnf, 0, 0, 12));
    addIns(3, encode(opSw, 1, 0, 'h6C));
    addIns(3, encode(opSw, 1, 0, 'h70));
    addIns(3, encode(opJ, 0, 0, 14));
    addIns(3, encode(opSw, 2, 0, 'h74));
    addIns(3, encode(opSw, 1, 0, 'h78));
    addIns(3, encode(opHalt, 0, 0, 0));
    expectStore(3, 'h68, 4'b1111, 32'd9);
    expectStore(3, 'h78, 4'b1111, 32'd5);
    // Test 4 nothing after HALT stores
    addIns(4, encode(opAddi, 1, 0, 77));
    addIns(4, encode(opSw, 1, 0, 'h80));
    addIns(4, encode(opHalt, 0, 0, 0));
    addIns(4, encode(opSw, 1, 0, 'h84));
    addIns(4, encode(opSw, 1, 0, 'h88));
    expectStore(4, 'h80, 4'b1111, 32'd77);
    // Test 5 sum of ten LFSR immediates
    lfsr = 16'd71;
    acc  = '0;
    for (int k = 0; k < 10; k++) begin
      imm = '0;
      for (int i = 0; i < immWidth; i++) begin
        lfsr = lfsrStep(lfsr);                          // One step per bit
        imm  = {imm[9:0], lfsr[0]};
      end
      acc = acc + {{(dataWidth - immWidth){imm[immWidth-1]}}, imm};
      addIns(5, encode(opAddi, 1, (k == 0) ? 0 : 1, int'(imm)));
    end
    addIns(5, encode(opSw, 1, 0, 'hC0));
    addIns(5, encode(opHalt, 0, 0, 0));
    expectStore(5, 'hC0, 4'b1111, acc);
  endtask

  // **************************************************
  // Test sequencing
  // **************************************************
  task automatic loadMemories(input int t);
    for (int a = 0; a < 1024; a++) begin
      if (a < progLen[t])
        imem[a] = progTable[t][a];
      else
        imem[a] = encode(opHalt, 0, 0, a);              // Stray fetch stops the core
    end
    for (int i = 0; i < 256; i++)
      dmem[i] <= {8'hD0, 8'(i), 8'(255 - i), 8'(i) ^ 8'h3C};
  endtask

  task automatic runTest(input int t);
    logic [pcWidth-1:0] heldPc;
    int n;
    @(posedge iClk);
    #1;
    rstN = 1'b0;
    loadMemories(t);
    seenQ.delete();
    loadCount = 0;
    repeat (resetCycles) @(posedge iClk);
    #1;
    checkValue("pc", 32'(pc), 32'd0);                   // Reset state
    checkValue("taskFinished", 32'(taskFinished), 32'd0);
    checkValue("dmemReq.we", 32'(dmemReq.we), 32'd0);
    checkValue("dmemReq.re", 32'(dmemReq.re), 32'd0);
    rstN = 1'b1;
    @(posedge iClk);
    #1;
    while (!taskFinished) begin
      @(posedge iClk);
      #1;
    end
    heldPc = pc;
    repeat (drainCycles) @(posedge iClk);
    #1;
    checkValue("taskFinished", 32'(taskFinished), 32'd1);  // Sticky
    checkValue("pc", 32'(pc), 32'(heldPc));                 // Frozen
    checkValue($sformatf("dmemReq.re count[%0d]", t), 32'(loadCount), 32'(expLoadCount[t]));
    assert (seenQ.size() == expCount[t]) else begin
      otherErrors++;
      $display("Test %0d issued %0d stores but %0d were expected",
               t, seenQ.size(), expCount[t]);
    end
    n = (seenQ.size() < expCount[t]) ? seenQ.size() : expCount[t];
    for (int i = 0; i < n; i++) begin
      checkValue($sformatf("dmemReq.addr[%0d.%0d]", t, i), seenQ[i].addr, expTable[t][i].addr);
      checkValue($sformatf("dmemReq.byteSel[%0d.%0d]", t, i),
                 32'(seenQ[i].sel), 32'(expTable[t][i].sel));
      checkValue($sformatf("dmemReq.wdata[%0d.%0d]", t, i), seenQ[i].data, expTable[t][i].data);
    end
  endtask

  initial begin
    rstN        = 1'b0;
    valueErrors = 0;
    otherErrors = 0;
    loadCount   = 0;
    buildTable();
    loadMemories(0);
    for (int t = 0; t < numTests; t++)
      runTest(t);
    $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
    if (valueErrors + otherErrors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog, 64 cycles per test plus margin
  initial begin
    #(clkPeriod * (numTests * 64 + 20));
    $display("Timeout: the DUT did not reach taskFinished in time");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
